//--- files.f
nrv_pkg.sv
nrv_regfile.sv
nrv_alu.sv
nrv_decoder.sv
nrv_flow_ctrl.sv
nrv_core.sv
nrv_core_assertions.sv
tb_nrv_core.sv

//--- nrv_alu.sv
//==========================================================
// ALU with result and operand equality flag
//==========================================================
`timescale 1ns/1ps

module nrv_alu
   import nrv_pkg::*;
(
   input  alu_op_t         alu_op,
   input  logic [XLEN-1:0] porta,
   input  logic [XLEN-1:0] portb,
   output logic [XLEN-1:0] alu_res,
   output logic            alu_eq
);

   always_comb begin
      case (alu_op)
         ALU_ADD:    alu_res = porta + portb;
         ALU_SUB:    alu_res = porta - portb;
         ALU_AND:    alu_res = porta & portb;
         ALU_OR:     alu_res = porta | portb;
         ALU_XOR:    alu_res = porta ^ portb;
         // LUI passes the upper immediate straight through
         ALU_PASS_B: alu_res = portb;
         default:    alu_res = porta + portb;
      endcase
   end

   // Branch condition independent of the selected operation
   assign alu_eq = (porta == portb);

endmodule

//--- nrv_core.sv
//==========================================================
// Top level of the two-stage RV32I subset core
//==========================================================
`timescale 1ns/1ps

module nrv_core
   import nrv_pkg::*;
#(
   parameter int NUM_REGS = 32
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic [XLEN-1:0] codemem_rdata,
   input  logic            codemem_ack,
   input  logic [XLEN-1:0] datamem_rdata,
   input  logic            datamem_ack,
   output logic [XLEN-1:0] codemem_addr,
   output logic [XLEN-1:0] datamem_addr,
   output logic [XLEN-1:0] datamem_wdata,
   output logic [3:0]      datamem_bytesel,
   output logic            datamem_req
);

   logic [REG_ADDR_W-1:0] rs1_idx;
   logic [REG_ADDR_W-1:0] rs2_idx;
   logic [REG_ADDR_W-1:0] rd_idx;
   logic [XLEN-1:0]       imm;
   logic [XLEN-1:0]       branch_offset;
   alu_op_t               alu_op;
   porta_sel_t            porta_sel;
   portb_sel_t            portb_sel;
   pc_sel_t               pc_sel;
   rd_src_t               rd_src;
   logic                  rd_write;
   logic                  mem_read;
   logic                  mem_write;
   logic                  branch_on_ne;
   logic [XLEN-1:0]       rs1_data;
   logic [XLEN-1:0]       rs2_data;
   logic [XLEN-1:0]       rd_data;
   logic                  rd_we;
   logic [XLEN-1:0]       porta;
   logic [XLEN-1:0]       portb;
   logic [XLEN-1:0]       alu_res;
   logic                  alu_eq;
   logic [XLEN-1:0]       pc_exe;
   logic                  fetch_valid;
   logic                  exe_valid;
   logic                  mem_rd_q;
   logic                  mem_wr_q;

   //==========================================================
   // Operand and write-back selection
   //==========================================================
   assign porta = (porta_sel == PA_PC_EXE) ? pc_exe : rs1_data;
   assign portb = (portb_sel == PB_IMM) ? imm : rs2_data;

   always_comb begin
      case (rd_src)
         RD_MEM:      rd_data = datamem_rdata;
         RD_PC_PLUS4: rd_data = pc_exe + XLEN'(4);
         default:     rd_data = alu_res;
      endcase
   end

   // No write while a load still waits for its data
   assign rd_we = rd_write & exe_valid & ~(datamem_req & ~datamem_ack);

   //==========================================================
   // Data memory port
   //==========================================================
   assign mem_rd_q        = mem_read & exe_valid;
   assign mem_wr_q        = mem_write & exe_valid;
   assign datamem_req     = mem_rd_q | mem_wr_q;
   assign datamem_bytesel = {4{mem_wr_q}};
   assign datamem_addr    = alu_res;
   assign datamem_wdata   = rs2_data;

   nrv_decoder u_decoder (
      .clk           (clk),
      .rst_n         (rst_n),
      .fetch_valid   (fetch_valid),
      .codemem_rdata (codemem_rdata),
      .rs1_idx       (rs1_idx),
      .rs2_idx       (rs2_idx),
      .rd_idx        (rd_idx),
      .imm           (imm),
      .branch_offset (branch_offset),
      .alu_op        (alu_op),
      .porta_sel     (porta_sel),
      .portb_sel     (portb_sel),
      .pc_sel        (pc_sel),
      .rd_src        (rd_src),
      .rd_write      (rd_write),
      .mem_read      (mem_read),
      .mem_write     (mem_write),
      .branch_on_ne  (branch_on_ne)
   );

   nrv_regfile #(
      .NUM_REGS (NUM_REGS)
   ) u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1_idx  (rs1_idx),
      .rs2_idx  (rs2_idx),
      .rd_idx   (rd_idx),
      .rd_data  (rd_data),
      .rd_we    (rd_we),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   nrv_alu u_alu (
      .alu_op  (alu_op),
      .porta   (porta),
      .portb   (portb),
      .alu_res (alu_res),
      .alu_eq  (alu_eq)
   );

   nrv_flow_ctrl u_flow_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .pc_sel        (pc_sel),
      .branch_on_ne  (branch_on_ne),
      .alu_eq        (alu_eq),
      .alu_res       (alu_res),
      .branch_offset (branch_offset),
      .codemem_ack   (codemem_ack),
      .datamem_req   (datamem_req),
      .datamem_ack   (datamem_ack),
      .codemem_addr  (codemem_addr),
      .pc_exe        (pc_exe),
      .fetch_valid   (fetch_valid),
      .exe_valid     (exe_valid)
   );

endmodule

//--- nrv_core_assertions.sv
//==========================================================
// Port assertions bound into the core top level
//==========================================================
`timescale 1ns/1ps

module nrv_core_assertions
   import nrv_pkg::*;
(
   input logic            clk,
   input logic            rst_n,
   input logic [XLEN-1:0] codemem_addr,
   input logic [3:0]      datamem_bytesel,
   input logic            datamem_req
);

   int fail_count = 0;

   // Byte select is all or nothing, and all only with a request
   a_bytesel: assert property (@(posedge clk) disable iff (!rst_n)
      (datamem_bytesel == 4'h0) || ((datamem_bytesel == 4'hF) && datamem_req))
   else begin
      $error("datamem_bytesel %h with datamem_req %b", datamem_bytesel, datamem_req);
      fail_count++;
   end

   a_code_align: assert property (@(posedge clk) disable iff (!rst_n)
      codemem_addr[1:0] == 2'b00)
   else begin
      $error("codemem_addr %h not word aligned", codemem_addr);
      fail_count++;
   end

   // Reset word is a jump, so no data access right after reset
   a_req_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !datamem_req)
   else begin
      $error("datamem_req high in first cycle after reset");
      fail_count++;
   end

endmodule

bind nrv_core nrv_core_assertions u_assertions (
   .clk             (clk),
   .rst_n           (rst_n),
   .codemem_addr    (codemem_addr),
   .datamem_bytesel (datamem_bytesel),
   .datamem_req     (datamem_req)
);

//--- nrv_decoder.sv
//==========================================================
// Instruction register, immediates and control decode
//==========================================================
`timescale 1ns/1ps

module nrv_decoder
   import nrv_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  fetch_valid,
   input  logic [XLEN-1:0]       codemem_rdata,
   output logic [REG_ADDR_W-1:0] rs1_idx,
   output logic [REG_ADDR_W-1:0] rs2_idx,
   output logic [REG_ADDR_W-1:0] rd_idx,
   output logic [XLEN-1:0]       imm,
   output logic [XLEN-1:0]       branch_offset,
   output alu_op_t               alu_op,
   output porta_sel_t            porta_sel,
   output portb_sel_t            portb_sel,
   output pc_sel_t               pc_sel,
   output rd_src_t               rd_src,
   output logic                  rd_write,
   output logic                  mem_read,
   output logic                  mem_write,
   output logic                  branch_on_ne
);

   logic [XLEN-1:0]     instr_r;
   logic [OPCODE_W-1:0] opcode;
   logic [FUNCT3_W-1:0] funct3;
   logic [FUNCT7_W-1:0] funct7;
   logic [XLEN-1:0]     imm_i;
   logic [XLEN-1:0]     imm_s;
   logic [XLEN-1:0]     imm_u;
   logic [XLEN-1:0]     imm_j;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr_r <= INSTR_J0;
      end else if (fetch_valid) begin
         instr_r <= codemem_rdata;
      end
   end

   //==========================================================
   // Fields and immediates
   //==========================================================
   assign opcode  = instr_r[OPCODE_LSB +: OPCODE_W];
   assign funct3  = instr_r[FUNCT3_LSB +: FUNCT3_W];
   assign funct7  = instr_r[FUNCT7_LSB +: FUNCT7_W];
   assign rd_idx  = instr_r[RD_LSB +: REG_ADDR_W];
   assign rs1_idx = instr_r[RS1_LSB +: REG_ADDR_W];
   assign rs2_idx = instr_r[RS2_LSB +: REG_ADDR_W];

   assign imm_i = {{20{instr_r[31]}}, instr_r[31:20]};
   assign imm_s = {{20{instr_r[31]}}, instr_r[31:25], instr_r[11:7]};
   assign imm_u = {instr_r[31:12], 12'b0};
   assign imm_j = {{12{instr_r[31]}}, instr_r[19:12], instr_r[20], instr_r[30:21], 1'b0};
   // B-type offset always presented for the branch adder
   assign branch_offset = {{20{instr_r[31]}}, instr_r[7], instr_r[30:25],
                           instr_r[11:8], 1'b0};

   //==========================================================
   // Control decode
   //==========================================================
   always_comb begin
      // No-op controls unless a kept instruction matches
      alu_op       = ALU_ADD;
      porta_sel    = PA_RS1;
      portb_sel    = PB_RS2;
      pc_sel       = PC_PLUS4;
      rd_src       = RD_ALU;
      rd_write     = 1'b0;
      mem_read     = 1'b0;
      mem_write    = 1'b0;
      branch_on_ne = 1'b0;
      imm          = imm_i;
      casez ({funct7, funct3, opcode})
         {F7_BASE, F3_ADD_SUB, OP_REG}: begin
            alu_op   = ALU_ADD;
            rd_write = 1'b1;
         end
         {F7_SUB, F3_ADD_SUB, OP_REG}: begin
            alu_op   = ALU_SUB;
            rd_write = 1'b1;
         end
         {F7_BASE, F3_AND, OP_REG}: begin
            alu_op   = ALU_AND;
            rd_write = 1'b1;
         end
         {F7_BASE, F3_OR, OP_REG}: begin
            alu_op   = ALU_OR;
            rd_write = 1'b1;
         end
         {F7_BASE, F3_XOR, OP_REG}: begin
            alu_op   = ALU_XOR;
            rd_write = 1'b1;
         end
         {7'b???????, F3_ADD_SUB, OP_IMM}: begin
            portb_sel = PB_IMM;
            rd_write  = 1'b1;
         end
         {7'b???????, F3_AND, OP_IMM}: begin
            alu_op    = ALU_AND;
            portb_sel = PB_IMM;
            rd_write  = 1'b1;
         end
         {7'b???????, F3_OR, OP_IMM}: begin
            alu_op    = ALU_OR;
            portb_sel = PB_IMM;
            rd_write  = 1'b1;
         end
         {7'b???????, F3_XOR, OP_IMM}: begin
            alu_op    = ALU_XOR;
            portb_sel = PB_IMM;
            rd_write  = 1'b1;
         end
         {10'b??????????, OP_LUI}: begin
            alu_op    = ALU_PASS_B;
            portb_sel = PB_IMM;
            imm       = imm_u;
            rd_write  = 1'b1;
         end
         {7'b???????, F3_WORD, OP_LOAD}: begin
            portb_sel = PB_IMM;
            rd_src    = RD_MEM;
            mem_read  = 1'b1;
            rd_write  = 1'b1;
         end
         {7'b???????, F3_WORD, OP_STORE}: begin
            portb_sel = PB_IMM;
            imm       = imm_s;
            mem_write = 1'b1;
         end
         // Branches compare rs1 against rs2
         {7'b???????, F3_BEQ, OP_BRANCH}: pc_sel = PC_COND_BRANCH;
         {7'b???????, F3_BNE, OP_BRANCH}: begin
            pc_sel       = PC_COND_BRANCH;
            branch_on_ne = 1'b1;
         end
         {10'b??????????, OP_JAL}: begin
            porta_sel = PA_PC_EXE;
            portb_sel = PB_IMM;
            imm       = imm_j;
            pc_sel    = PC_ALU_RES;
            rd_src    = RD_PC_PLUS4;
            rd_write  = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

//--- nrv_flow_ctrl.sv
//==========================================================
// Program counters, branch resolution and pipeline FSM
//==========================================================
`timescale 1ns/1ps

module nrv_flow_ctrl
   import nrv_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  pc_sel_t         pc_sel,
   input  logic            branch_on_ne,
   input  logic            alu_eq,
   input  logic [XLEN-1:0] alu_res,
   input  logic [XLEN-1:0] branch_offset,
   input  logic            codemem_ack,
   input  logic            datamem_req,
   input  logic            datamem_ack,
   output logic [XLEN-1:0] codemem_addr,
   output logic [XLEN-1:0] pc_exe,
   output logic            fetch_valid,
   output logic            exe_valid
);

   pstate_t         pstate_r;
   pstate_t         pstate_next;
   logic [XLEN-1:0] pc_fetch_r;
   logic            branch_taken;
   logic            stall;
   logic            mem_wait;

   assign mem_wait = datamem_req & ~datamem_ack;

   // Only a valid instruction in execute may redirect fetch
   always_comb begin
      case (pc_sel)
         PC_COND_BRANCH: branch_taken = exe_valid & (alu_eq ^ branch_on_ne);
         PC_ALU_RES:     branch_taken = exe_valid;
         default:        branch_taken = 1'b0;
      endcase
   end

   //==========================================================
   // Pipeline state machine
   //==========================================================
   always_comb begin
      fetch_valid = 1'b0;
      stall       = 1'b0;
      pstate_next = pstate_r;
      case (pstate_r)
         PS_RESET: pstate_next = branch_taken ? PS_BRANCH : PS_CONT;
         PS_CONT: begin
            if (branch_taken) begin
               pstate_next = PS_BRANCH;
            end else if (mem_wait) begin
               stall       = 1'b1;
               pstate_next = PS_STALL;
            end else begin
               fetch_valid = codemem_ack;
            end
         end
         PS_BRANCH: begin
            // Wait for the target word
            fetch_valid = codemem_ack;
            if (codemem_ack) begin
               pstate_next = PS_CONT;
            end
         end
         PS_STALL: begin
            if (mem_wait) begin
               stall = 1'b1;
            end else begin
               fetch_valid = codemem_ack;
               pstate_next = PS_CONT;
            end
         end
      endcase
   end

   // Fetch address held until the code word is taken
   always_comb begin
      if (branch_taken) begin
         codemem_addr = (pc_sel == PC_COND_BRANCH) ? pc_exe + branch_offset : alu_res;
      end else if (fetch_valid) begin
         codemem_addr = pc_fetch_r + XLEN'(4);
      end else begin
         codemem_addr = pc_fetch_r;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pstate_r   <= PS_RESET;
         pc_fetch_r <= '0;
         pc_exe     <= '0;
         exe_valid  <= 1'b1;
      end else begin
         pstate_r   <= pstate_next;
         pc_fetch_r <= codemem_addr;
         exe_valid  <= fetch_valid | stall;
         if (fetch_valid) begin
            pc_exe <= pc_fetch_r;
         end
      end
   end

endmodule

//--- nrv_pkg.sv
//==========================================================
// Shared definitions for the two-stage RV32I subset core
//==========================================================
package nrv_pkg;

   //==========================================================
   // Widths and fixed instruction words
   //==========================================================
   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   // ADDI x0, x0, 0
   localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;
   // JAL x0, 0 loaded into the instruction register at reset
   localparam logic [XLEN-1:0] INSTR_J0  = 32'h0000_006F;

   // Instruction field positions
   localparam int OPCODE_LSB = 0;
   localparam int RD_LSB     = 7;
   localparam int FUNCT3_LSB = 12;
   localparam int RS1_LSB    = 15;
   localparam int RS2_LSB    = 20;
   localparam int FUNCT7_LSB = 25;
   localparam int OPCODE_W   = 7;
   localparam int FUNCT3_W   = 3;
   localparam int FUNCT7_W   = 7;

   //==========================================================
   // Opcode and function codes
   //==========================================================
   localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
   localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
   localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
   localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
   localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
   localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
   localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;

   localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
   localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
   localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
   localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;
   localparam logic [FUNCT3_W-1:0] F3_WORD    = 3'b010;
   localparam logic [FUNCT3_W-1:0] F3_BEQ     = 3'b000;
   localparam logic [FUNCT3_W-1:0] F3_BNE     = 3'b001;

   localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
   localparam logic [FUNCT7_W-1:0] F7_SUB  = 7'b0100000;

   //==========================================================
   // Datapath selects and pipeline state
   //==========================================================
   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
   } alu_op_t;

   typedef enum logic {PA_RS1, PA_PC_EXE} porta_sel_t;

   typedef enum logic {PB_RS2, PB_IMM} portb_sel_t;

   typedef enum logic [1:0] {PC_PLUS4, PC_COND_BRANCH, PC_ALU_RES} pc_sel_t;

   typedef enum logic [1:0] {RD_ALU, RD_MEM, RD_PC_PLUS4} rd_src_t;

   typedef enum logic [1:0] {PS_RESET, PS_CONT, PS_BRANCH, PS_STALL} pstate_t;

endpackage

//--- nrv_regfile.sv
//==========================================================
// Register file with two async read ports and one write port
//==========================================================
`timescale 1ns/1ps

module nrv_regfile
   import nrv_pkg::*;
#(
   parameter int NUM_REGS = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [REG_ADDR_W-1:0] rs1_idx,
   input  logic [REG_ADDR_W-1:0] rs2_idx,
   input  logic [REG_ADDR_W-1:0] rd_idx,
   input  logic [XLEN-1:0]       rd_data,
   input  logic                  rd_we,
   output logic [XLEN-1:0]       rs1_data,
   output logic [XLEN-1:0]       rs2_data
);

   localparam int IDX_W = $clog2(NUM_REGS);

   logic [XLEN-1:0]  regs [NUM_REGS];
   logic [IDX_W-1:0] rs1_sel;
   logic [IDX_W-1:0] rs2_sel;
   logic [IDX_W-1:0] rd_sel;

   // Upper index bits are ignored for a 16-entry file
   assign rs1_sel = rs1_idx[IDX_W-1:0];
   assign rs2_sel = rs2_idx[IDX_W-1:0];
   assign rd_sel  = rd_idx[IDX_W-1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_we && (rd_sel != '0)) begin
         regs[rd_sel] <= rd_data;
      end
   end

   // x0 is hardwired to zero
   assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
   assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

endmodule

//--- tb_nrv_core.sv
//==========================================================
// Testbench for the two-stage RV32I subset core
//==========================================================
`timescale 1ns/1ps

module tb_nrv_core;

   localparam int          NUM_PHASES = 2;
   localparam int          MEM_WORDS  = 64;
   localparam logic [31:0] NO_STORE   = 32'hFFFF_FFFF;
   localparam logic [31:0] LOAD_ADDR  = 32'h0000_00C0;

   logic        clk = 1'b0;
   logic        rst_n;
   logic [31:0] codemem_rdata;
   logic        codemem_ack;
   logic [31:0] datamem_rdata;
   logic        datamem_ack;
   logic [31:0] codemem_addr;
   logic [31:0] datamem_addr;
   logic [31:0] datamem_wdata;
   logic [3:0]  datamem_bytesel;
   logic        datamem_req;

   // Program table with one code word per row
   logic [31:0] prog_instr[$];
   logic [31:0] prog_st_addr[$];
   logic [31:0] prog_st_data[$];
   // Stores still expected in program order
   logic [31:0] exp_addr_q[$];
   logic [31:0] exp_data_q[$];

   logic [31:0] code_mem [MEM_WORDS];
   logic [31:0] data_mem [MEM_WORDS];
   logic [31:0] fetch_addr_q;
   logic [31:0] rnd_code;
   logic [31:0] rnd_data;
   logic        random_acks;
   logic        first_pending;
   logic        table_built = 1'b0;
   integer      seed = 32'ha7b;
   int          errors;
   int          stores_seen;

   nrv_core #(
      .NUM_REGS (32)
   ) u_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .codemem_rdata   (codemem_rdata),
      .codemem_ack     (codemem_ack),
      .datamem_rdata   (datamem_rdata),
      .datamem_ack     (datamem_ack),
      .codemem_addr    (codemem_addr),
      .datamem_addr    (datamem_addr),
      .datamem_wdata   (datamem_wdata),
      .datamem_bytesel (datamem_bytesel),
      .datamem_req     (datamem_req)
   );

   always #5 clk = ~clk;

   //==========================================================
   // Instruction encoding and memory contents
   //==========================================================
   function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
      return {imm, rs1, 3'b010, rd, 7'b0000011};
   endfunction

   function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // Data memory preload pattern keyed by byte address
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h0001_0193) ^ 32'h5A5A_0000;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         errors++;
         $display("ERR %0t %s: got %08h, expected %08h", $time, name, actual, expected);
      end
   endtask

   task automatic add_row(input logic [31:0] instr, input logic [31:0] st_addr,
                          input logic [31:0] st_data);
      prog_instr.push_back(instr);
      prog_st_addr.push_back(st_addr);
      prog_st_data.push_back(st_data);
   endtask

   task automatic build_program();
      logic [31:0] jal_pc;
      // Build x1 = 0x12345678 and combine it through the ALU operations
      add_row(lui_word(5'd1, 20'h12345), NO_STORE, '0);
      add_row(imm_op(3'b000, 5'd1, 5'd1, 12'h678), NO_STORE, '0);
      add_row(store_word(5'd1, 5'd0, 12'h000), 32'h00, 32'h1234_5678);
      add_row(imm_op(3'b000, 5'd2, 5'd0, 12'hFFF), NO_STORE, '0);
      add_row(imm_op(3'b111, 5'd3, 5'd1, 12'h0F0), NO_STORE, '0);
      add_row(imm_op(3'b110, 5'd4, 5'd3, 12'h700), NO_STORE, '0);
      add_row(imm_op(3'b100, 5'd5, 5'd1, 12'hFFF), NO_STORE, '0);
      add_row(reg_op(7'h00, 3'b000, 5'd6, 5'd1, 5'd4), NO_STORE, '0);
      add_row(store_word(5'd6, 5'd0, 12'h004), 32'h04, 32'h1234_5678 + 32'h770);
      add_row(reg_op(7'h20, 3'b000, 5'd7, 5'd3, 5'd1), NO_STORE, '0);
      add_row(store_word(5'd7, 5'd0, 12'h008), 32'h08, 32'h70 - 32'h1234_5678);
      add_row(reg_op(7'h00, 3'b111, 5'd8, 5'd5, 5'd4), NO_STORE, '0);
      add_row(store_word(5'd8, 5'd0, 12'h00C), 32'h0C, ~32'h1234_5678 & 32'h770);
      add_row(reg_op(7'h00, 3'b110, 5'd9, 5'd1, 5'd4), NO_STORE, '0);
      add_row(store_word(5'd9, 5'd0, 12'h010), 32'h10, 32'h1234_5678 | 32'h770);
      add_row(reg_op(7'h00, 3'b100, 5'd10, 5'd6, 5'd1), NO_STORE, '0);
      add_row(store_word(5'd10, 5'd0, 12'h014), 32'h14, 32'h1234_5DE8 ^ 32'h1234_5678);
      // Load, increment and store back
      add_row(load_word(5'd11, 5'd0, LOAD_ADDR[11:0]), NO_STORE, '0);
      add_row(imm_op(3'b000, 5'd11, 5'd11, 12'h001), NO_STORE, '0);
      add_row(store_word(5'd11, 5'd0, 12'h018), 32'h18, fill_word(LOAD_ADDR) + 32'd1);
      // Write to x0 is lost
      add_row(imm_op(3'b000, 5'd0, 5'd1, 12'h005), NO_STORE, '0);
      add_row(store_word(5'd0, 5'd0, 12'h01C), 32'h1C, 32'h0);
      // Stores in skipped branch slots carry no expectation
      add_row(branch_word(3'b000, 5'd1, 5'd6, 13'd8), NO_STORE, '0);
      add_row(store_word(5'd3, 5'd0, 12'h020), 32'h20, 32'h70);
      add_row(branch_word(3'b000, 5'd3, 5'd3, 13'd8), NO_STORE, '0);
      add_row(store_word(5'd2, 5'd0, 12'h024), NO_STORE, '0);
      add_row(branch_word(3'b001, 5'd3, 5'd3, 13'd8), NO_STORE, '0);
      add_row(store_word(5'd4, 5'd0, 12'h028), 32'h28, 32'h770);
      add_row(branch_word(3'b001, 5'd1, 5'd6, 13'd8), NO_STORE, '0);
      add_row(store_word(5'd2, 5'd0, 12'h02C), NO_STORE, '0);
      jal_pc = 32'(4 * prog_instr.size());
      add_row(jal_word(5'd12, 21'd8), NO_STORE, '0);
      add_row(store_word(5'd2, 5'd0, 12'h030), NO_STORE, '0);
      add_row(store_word(5'd12, 5'd0, 12'h034), 32'h34, jal_pc + 32'd4);
      // Park the core in a tight loop
      add_row(jal_word(5'd0, 21'd0), NO_STORE, '0);
   endtask

   task automatic run_phase(input logic use_random);
      @(negedge clk);
      rst_n         = 1'b0;
      random_acks   = use_random;
      first_pending = 1'b0;
      exp_addr_q.delete();
      exp_data_q.delete();
      for (int i = 0; i < prog_instr.size(); i++) begin
         if (prog_st_addr[i] != NO_STORE) begin
            exp_addr_q.push_back(prog_st_addr[i]);
            exp_data_q.push_back(prog_st_data[i]);
         end
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         data_mem[i] = fill_word(32'(i * 4));
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      first_pending = 1'b1;
      while (exp_addr_q.size() != 0) begin
         @(posedge clk);
      end
      // Quiet period to catch a late extra store
      repeat (10) @(posedge clk);
   endtask

   //==========================================================
   // Memory models and store checker
   //==========================================================
   always @(posedge clk) begin
      fetch_addr_q <= codemem_addr;
   end

   always @(negedge clk) begin
      rnd_code = $random(seed);
      rnd_data = $random(seed);
      codemem_rdata <= code_mem[fetch_addr_q[7:2]];
      codemem_ack   <= random_acks ? rnd_code[0] : 1'b1;
      datamem_rdata <= data_mem[datamem_addr[7:2]];
      datamem_ack   <= random_acks ? rnd_data[0] : 1'b1;
   end

   always @(posedge clk) begin
      if (rst_n && first_pending && codemem_ack) begin
         check_value("codemem_addr", fetch_addr_q, 32'h0);
         first_pending = 1'b0;
      end
      if (rst_n && datamem_req && datamem_ack && (datamem_bytesel == 4'hF)) begin
         data_mem[datamem_addr[7:2]] = datamem_wdata;
         stores_seen++;
         if (exp_addr_q.size() == 0) begin
            errors++;
            $display("Store to %08h at %0t with no expected store left", datamem_addr, $time);
         end else begin
            check_value("datamem_addr", datamem_addr, exp_addr_q.pop_front());
            check_value("datamem_wdata", datamem_wdata, exp_data_q.pop_front());
         end
      end
   end

   //==========================================================
   // Watchdog and main sequence
   //==========================================================
   initial begin
      wait (table_built);
      repeat (NUM_PHASES * (prog_instr.size() * 40 + 100)) @(posedge clk);
      $display("Timeout at %0t with %0d expected stores never seen", $time, exp_addr_q.size());
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      rst_n         = 1'b0;
      codemem_rdata = '0;
      codemem_ack   = 1'b0;
      datamem_rdata = '0;
      datamem_ack   = 1'b0;
      random_acks   = 1'b0;
      first_pending = 1'b0;
      errors        = 0;
      stores_seen   = 0;
      build_program();
      // Unused words hold no-ops tagged with their own address
      for (int i = 0; i < MEM_WORDS; i++) begin
         code_mem[i] = (i < prog_instr.size()) ? prog_instr[i]
                                                : imm_op(3'b000, 5'd0, 5'd0, 12'(i * 4));
      end
      table_built = 1'b1;
      // First pass with ready memories, then with random wait states
      for (int phase = 0; phase < NUM_PHASES; phase++) begin
         run_phase(phase != 0);
      end
      errors += u_dut.u_assertions.fail_count;
      $display("Errors: %0d, stores checked: %0d", errors, stores_seen);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
